// File: Bender.yml
package:
  name: ulpi_link

sources:
  # RTL in compile order
  - files:
      - hdl/ulpi_pkg.sv
      - hdl/ulpi_ctrl.sv
      - hdl/ulpi_reg_write.sv
      - hdl/ulpi_reg_read.sv
      - hdl/ulpi_rx.sv
      - hdl/ulpi_link.sv
  # Testbench and bound protocol checks
  - target: simulation
    files:
      - sim/ulpi_link_properties.sv
      - sim/tb_ulpi_link.sv

// File: filelist.f
hdl/ulpi_pkg.sv
hdl/ulpi_ctrl.sv
hdl/ulpi_reg_write.sv
hdl/ulpi_reg_read.sv
hdl/ulpi_rx.sv
hdl/ulpi_link.sv
sim/ulpi_link_properties.sv
sim/tb_ulpi_link.sv

// File: hdl/ulpi_ctrl.sv
// ULPI link controller
// Arbitrates the ULPI bus between the PHY and the register engines,
// issues the engine start pulses, reports completion to the user side
// and multiplexes the engine bus outputs onto the link pins

`timescale 1ns/1ps

module ulpi_ctrl (
    input  logic                clk,
    input  logic                rst,
    // User requests
    input  logic                reg_wr,        // Level request, register write
    input  logic                reg_rd,        // Level request, register read
    // ULPI direction from the PHY
    input  logic                ulpi_dir,
    // Register-write engine
    input  logic                wr_busy,
    input  logic                wr_done,
    input  logic                wr_abort,
    input  logic                wr_err,
    input  ulpi_pkg::ulpi_byte_t wr_data,
    input  logic                wr_stp,
    // Register-read engine
    input  logic                rd_busy,
    input  logic                rd_done,
    input  logic                rd_abort,
    input  logic                rd_err,
    input  ulpi_pkg::ulpi_byte_t rd_data,
    // Engine control
    output logic                wr_start,      // One-cycle start pulse
    output logic                rd_start,      // One-cycle start pulse
    output logic                rx_en,         // Receiver qualifier
    // User status
    output logic                busy,
    output logic                reg_done,
    output logic                reg_err,
    // Link side of the ULPI bus
    output ulpi_pkg::ulpi_byte_t ulpi_data_out,
    output logic                ulpi_stp,
    output logic                ulpi_data_oe
);

    ulpi_pkg::ctrl_state_t state;

    logic eng_done; // Done pulse of the engine that owns the bus
    logic eng_err;  // Error flag of that engine
    logic can_start;

    // No new access in the cycle reg_done is shown, the request is still up then
    assign can_start = (state == ulpi_pkg::IDLE) && !ulpi_dir && !reg_done;

    // Write wins over read when both are requested
    assign wr_start = can_start && reg_wr;
    assign rd_start = can_start && !reg_wr && reg_rd;

    assign eng_done = ((state == ulpi_pkg::REG_WRITE) && wr_done) ||
                      ((state == ulpi_pkg::REG_READ) && rd_done);
    assign eng_err  = (state == ulpi_pkg::REG_WRITE) ? wr_err : rd_err;

    assign busy  = (state != ulpi_pkg::IDLE);
    assign rx_en = (state == ulpi_pkg::RECEIVE); // Turnarounds of a read stay hidden

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ulpi_pkg::IDLE;
            reg_done <= 1'b0;
            reg_err  <= 1'b0;
        end else begin
            reg_done <= eng_done;
            reg_err  <= eng_done && eng_err;
            case (state)
                ulpi_pkg::IDLE: begin
                    if (ulpi_dir) begin
                        state <= ulpi_pkg::RECEIVE; // PHY has priority
                    end else if (wr_start) begin
                        state <= ulpi_pkg::REG_WRITE;
                    end else if (rd_start) begin
                        state <= ulpi_pkg::REG_READ;
                    end
                end
                ulpi_pkg::REG_WRITE: begin
                    // Abort leaves the request pending, it is reissued from IDLE
                    if (wr_done || wr_abort) begin
                        state <= ulpi_dir ? ulpi_pkg::RECEIVE : ulpi_pkg::IDLE;
                    end
                end
                ulpi_pkg::REG_READ: begin
                    if (rd_done || rd_abort) begin
                        state <= ulpi_dir ? ulpi_pkg::RECEIVE : ulpi_pkg::IDLE;
                    end
                end
                ulpi_pkg::RECEIVE: begin
                    if (!ulpi_dir) begin
                        state <= ulpi_pkg::IDLE; // PHY released the bus
                    end
                end
                default: state <= ulpi_pkg::IDLE;
            endcase
        end
    end

    // Bus mux, data 0 and STP low when no engine owns the bus
    always_comb begin
        ulpi_data_out = '0;
        ulpi_stp      = 1'b0;
        ulpi_data_oe  = 1'b0;
        case (state)
            ulpi_pkg::REG_WRITE: begin
                ulpi_data_out = wr_data;
                ulpi_stp      = wr_stp;
                ulpi_data_oe  = wr_busy && !ulpi_dir; // Off at once when DIR rises
            end
            ulpi_pkg::REG_READ: begin
                ulpi_data_out = rd_data;
                ulpi_data_oe  = rd_busy && !ulpi_dir; // Released across the turnaround
            end
            default: begin
                ulpi_data_out = '0;
            end
        endcase
    end

endmodule

// File: hdl/ulpi_link.sv
// ULPI link top level
// Controller plus register-write, register-read and receive engines
// on the PHY's 60 MHz clock, bus pins as data in, data out and enable

`timescale 1ns/1ps

module ulpi_link #(
    parameter int NXT_TIMEOUT = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    // User register access
    input  logic                 reg_wr,
    input  logic                 reg_rd,
    input  ulpi_pkg::ulpi_addr_t reg_addr,
    input  ulpi_pkg::ulpi_byte_t reg_wdata,
    output ulpi_pkg::ulpi_byte_t reg_rdata,
    output logic                 reg_done,
    output logic                 reg_err,
    output logic                 busy,
    // Received bytes
    output ulpi_pkg::ulpi_byte_t rx_cmd,
    output logic                 rx_cmd_valid,
    output ulpi_pkg::ulpi_byte_t rx_data,
    output logic                 rx_data_valid,
    // ULPI pins, tristate at the chip top
    input  logic                 ulpi_dir,
    input  logic                 ulpi_nxt,
    output logic                 ulpi_stp,
    input  ulpi_pkg::ulpi_byte_t ulpi_data_in,
    output ulpi_pkg::ulpi_byte_t ulpi_data_out,
    output logic                 ulpi_data_oe
);

    // Write engine
    logic                 wr_start;
    logic                 wr_busy;
    logic                 wr_done;
    logic                 wr_abort;
    logic                 wr_err;
    logic                 wr_stp;
    ulpi_pkg::ulpi_byte_t wr_data;

    // Read engine
    logic                 rd_start;
    logic                 rd_busy;
    logic                 rd_done;
    logic                 rd_abort;
    logic                 rd_err;
    ulpi_pkg::ulpi_byte_t rd_data;

    logic                 rx_en;

    ulpi_ctrl ulpi_ctrl_i (
        .clk(clk), .rst(rst), .reg_wr(reg_wr), .reg_rd(reg_rd), .ulpi_dir(ulpi_dir),
        .wr_busy(wr_busy), .wr_done(wr_done), .wr_abort(wr_abort), .wr_err(wr_err),
        .wr_data(wr_data), .wr_stp(wr_stp),
        .rd_busy(rd_busy), .rd_done(rd_done), .rd_abort(rd_abort), .rd_err(rd_err),
        .rd_data(rd_data),
        .wr_start(wr_start), .rd_start(rd_start), .rx_en(rx_en),
        .busy(busy), .reg_done(reg_done), .reg_err(reg_err),
        .ulpi_data_out(ulpi_data_out), .ulpi_stp(ulpi_stp), .ulpi_data_oe(ulpi_data_oe)
    );

    ulpi_reg_write #(.NXT_TIMEOUT(NXT_TIMEOUT)) ulpi_reg_write_i (
        .clk(clk), .rst(rst), .start(wr_start), .addr(reg_addr), .wdata(reg_wdata),
        .ulpi_dir(ulpi_dir), .ulpi_nxt(ulpi_nxt),
        .data_out(wr_data), .stp(wr_stp), .busy(wr_busy),
        .done(wr_done), .abort(wr_abort), .err(wr_err)
    );

    ulpi_reg_read #(.NXT_TIMEOUT(NXT_TIMEOUT)) ulpi_reg_read_i (
        .clk(clk), .rst(rst), .start(rd_start), .addr(reg_addr),
        .ulpi_dir(ulpi_dir), .ulpi_nxt(ulpi_nxt), .ulpi_data_in(ulpi_data_in),
        .data_out(rd_data), .rdata(reg_rdata), .busy(rd_busy),
        .done(rd_done), .abort(rd_abort), .err(rd_err)
    );

    ulpi_rx ulpi_rx_i (
        .clk(clk), .rst(rst), .rx_en(rx_en),
        .ulpi_dir(ulpi_dir), .ulpi_nxt(ulpi_nxt), .ulpi_data_in(ulpi_data_in),
        .rx_cmd(rx_cmd), .rx_cmd_valid(rx_cmd_valid),
        .rx_data(rx_data), .rx_data_valid(rx_data_valid)
    );

endmodule

// File: hdl/ulpi_pkg.sv
// ULPI link package
// Shared bus types, TX CMD prefixes and the controller state encoding
// used by the link controller and its register and receive engines

package ulpi_pkg;

    // One byte on the 8-bit ULPI data bus
    typedef logic [7:0] ulpi_byte_t;

    // Immediate PHY register address, carried in the low six TX CMD bits
    typedef logic [5:0] ulpi_addr_t;

    // TX CMD prefix, the top two bits of the command byte
    typedef logic [1:0] txcmd_prefix_t;

    // Register write command, {10, addr}
    localparam txcmd_prefix_t TXCMD_REGW = 2'b10;

    // Register read command, {11, addr}
    localparam txcmd_prefix_t TXCMD_REGR = 2'b11;

    // Controller states
    // IDLE      bus free, link waits for a request or for DIR
    // REG_WRITE register-write engine owns the bus
    // REG_READ  register-read engine owns the bus, turnarounds included
    // RECEIVE   PHY owns the bus, bytes go to the receiver
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        REG_WRITE = 2'd1,
        REG_READ  = 2'd2,
        RECEIVE   = 2'd3
    } ctrl_state_t;

endpackage

// File: hdl/ulpi_reg_read.sv
// ULPI register-read engine
// Sends the register read TX CMD until NXT, lets the PHY turn the bus
// around, captures the register byte and waits for DIR to fall again

`timescale 1ns/1ps

module ulpi_reg_read #(
    parameter int NXT_TIMEOUT = 16 // Cycles to wait for NXT, then for DIR
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  ulpi_pkg::ulpi_addr_t addr,
    input  logic                 ulpi_dir,
    input  logic                 ulpi_nxt,
    input  ulpi_pkg::ulpi_byte_t ulpi_data_in,
    output ulpi_pkg::ulpi_byte_t data_out,
    output ulpi_pkg::ulpi_byte_t rdata,
    output logic                 busy,
    output logic                 done,
    output logic                 abort,
    output logic                 err
);

    localparam int CNT_W = (NXT_TIMEOUT > 1) ? $clog2(NXT_TIMEOUT) : 1;

    typedef enum logic [2:0] {
        R_IDLE,
        R_CMD,  // TX CMD on the bus
        R_TURN, // Waiting for DIR, first DIR cycle is the turnaround
        R_DATA, // PHY drives the register byte
        R_WAIT  // Waiting for the PHY to release the bus
    } rd_phase_t;

    rd_phase_t        phase;
    logic [CNT_W-1:0] wait_cnt;
    logic             timeout;

    assign timeout = (wait_cnt == CNT_W'(NXT_TIMEOUT - 1));
    assign busy    = (phase != R_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= R_IDLE;
            wait_cnt <= '0;
        end else begin
            case (phase)
                R_IDLE: begin
                    wait_cnt <= '0;
                    if (start) phase <= R_CMD;
                end
                R_CMD: begin
                    if (ulpi_dir) begin
                        phase <= R_IDLE; // Aborted by the PHY
                    end else if (ulpi_nxt) begin
                        phase    <= R_TURN;
                        wait_cnt <= '0;
                    end else if (timeout) begin
                        phase <= R_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                R_TURN: begin
                    if (ulpi_dir) begin
                        phase <= R_DATA; // Turnaround cycle, no data yet
                    end else if (timeout) begin
                        phase <= R_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                R_DATA:  phase <= ulpi_dir ? R_WAIT : R_IDLE;
                R_WAIT:  if (!ulpi_dir) phase <= R_IDLE;
                default: phase <= R_IDLE;
            endcase
        end
    end

    // Register byte, valid from the cycle after it was on the bus
    always_ff @(posedge clk) begin
        if (phase == R_DATA && ulpi_dir) begin
            rdata <= ulpi_data_in;
        end
    end

    always_comb begin
        data_out = '0;
        abort    = 1'b0;
        done     = 1'b0;
        err      = 1'b0;
        case (phase)
            R_CMD: begin
                data_out = {ulpi_pkg::TXCMD_REGR, addr};
                abort    = ulpi_dir;
                err      = !ulpi_dir && !ulpi_nxt && timeout;
                done     = err;
            end
            R_TURN: begin
                err  = !ulpi_dir && timeout; // PHY never turned the bus
                done = err;
            end
            R_DATA: begin
                err  = !ulpi_dir; // Bus dropped before the byte
                done = err;
            end
            R_WAIT:  done = !ulpi_dir;
            default: data_out = '0;
        endcase
    end

endmodule

// File: hdl/ulpi_reg_write.sv
// ULPI register-write engine
// Sends the register write TX CMD, then the data byte, each held until
// the PHY raises NXT, and closes the access with a one-cycle STP

`timescale 1ns/1ps

module ulpi_reg_write #(
    parameter int NXT_TIMEOUT = 16 // Cycles to wait for NXT per byte
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  ulpi_pkg::ulpi_addr_t addr,
    input  ulpi_pkg::ulpi_byte_t wdata,
    input  logic                 ulpi_dir,
    input  logic                 ulpi_nxt,
    output ulpi_pkg::ulpi_byte_t data_out,
    output logic                 stp,
    output logic                 busy,
    output logic                 done,
    output logic                 abort,
    output logic                 err
);

    localparam int CNT_W = (NXT_TIMEOUT > 1) ? $clog2(NXT_TIMEOUT) : 1;

    typedef enum logic [1:0] {
        W_IDLE,
        W_CMD,  // TX CMD on the bus
        W_DATA, // Register data on the bus
        W_STOP  // STP with data 0
    } wr_phase_t;

    wr_phase_t        phase;
    logic [CNT_W-1:0] wait_cnt; // Cycles spent waiting for NXT
    logic             timeout;

    assign timeout = (wait_cnt == CNT_W'(NXT_TIMEOUT - 1));
    assign busy    = (phase != W_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= W_IDLE;
            wait_cnt <= '0;
        end else begin
            case (phase)
                W_IDLE: begin
                    wait_cnt <= '0;
                    if (start) phase <= W_CMD;
                end
                W_CMD: begin
                    if (ulpi_dir) begin
                        phase <= W_IDLE;    // PHY took the bus first
                    end else if (ulpi_nxt) begin
                        phase    <= W_DATA; // Command accepted
                        wait_cnt <= '0;
                    end else if (timeout) begin
                        phase <= W_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                W_DATA: begin
                    if (ulpi_nxt || timeout) begin
                        phase <= ulpi_nxt ? W_STOP : W_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                W_STOP:  phase <= W_IDLE;
                default: phase <= W_IDLE;
            endcase
        end
    end

    always_comb begin
        data_out = '0;
        stp      = 1'b0;
        abort    = 1'b0;
        done     = 1'b0;
        err      = 1'b0;
        case (phase)
            W_CMD: begin
                data_out = {ulpi_pkg::TXCMD_REGW, addr};
                abort    = ulpi_dir;
                err      = !ulpi_dir && !ulpi_nxt && timeout; // Never accepted
                done     = err;
            end
            W_DATA: begin
                data_out = wdata;
                err      = !ulpi_nxt && timeout;
                done     = err;
            end
            W_STOP: begin
                stp  = 1'b1; // Data stays 0 with STP
                done = 1'b1;
            end
            default: data_out = '0;
        endcase
    end

endmodule

// File: hdl/ulpi_rx.sv
// ULPI receiver
// Sorts the bytes the PHY sends while it owns the bus into RX CMD bytes
// (NXT low) and packet data bytes (NXT high), skipping the turnaround

`timescale 1ns/1ps

module ulpi_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_en,         // High while the controller is in RECEIVE
    input  logic                 ulpi_dir,
    input  logic                 ulpi_nxt,
    input  ulpi_pkg::ulpi_byte_t ulpi_data_in,
    output ulpi_pkg::ulpi_byte_t rx_cmd,        // Last RX CMD, held
    output logic                 rx_cmd_valid,
    output ulpi_pkg::ulpi_byte_t rx_data,
    output logic                 rx_data_valid
);

    logic dir_q;      // DIR one cycle back
    logic byte_valid; // PHY drives a real byte this cycle
    logic is_cmd;
    logic is_data;

    // A DIR cycle after another DIR cycle is past the turnaround
    assign byte_valid = rx_en && ulpi_dir && dir_q;
    assign is_cmd     = byte_valid && !ulpi_nxt;
    assign is_data    = byte_valid && ulpi_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            dir_q         <= 1'b0;
            rx_cmd_valid  <= 1'b0;
            rx_data_valid <= 1'b0;
        end else begin
            dir_q         <= ulpi_dir;
            rx_cmd_valid  <= is_cmd;  // One cycle behind the bus
            rx_data_valid <= is_data;
        end
    end

    // RX CMD carries line state and events, kept until the next one
    always_ff @(posedge clk) begin
        if (is_cmd) begin
            rx_cmd <= ulpi_data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (is_data) begin
            rx_data <= ulpi_data_in; // Packet byte
        end
    end

endmodule

// File: sim/tb_ulpi_link.sv
// ULPI link testbench
// Clock, reset and a behavioural PHY that answers register writes and
// reads, injects receive bursts, aborts a write and starves NXT

`timescale 1ns/1ps

module tb_ulpi_link;

    localparam int NXT_TIMEOUT = 8;  // Short timeout for the DUT
    localparam int WAIT_LIMIT  = 64; // Bound for every wait loop

    logic                 clk;
    logic                 rst;
    logic                 reg_wr;
    logic                 reg_rd;
    ulpi_pkg::ulpi_addr_t reg_addr;
    ulpi_pkg::ulpi_byte_t reg_wdata;
    ulpi_pkg::ulpi_byte_t reg_rdata;
    logic                 reg_done;
    logic                 reg_err;
    logic                 busy;
    ulpi_pkg::ulpi_byte_t rx_cmd;
    logic                 rx_cmd_valid;
    ulpi_pkg::ulpi_byte_t rx_data;
    logic                 rx_data_valid;
    logic                 ulpi_dir;
    logic                 ulpi_nxt;
    logic                 ulpi_stp;
    ulpi_pkg::ulpi_byte_t ulpi_data_in;
    ulpi_pkg::ulpi_byte_t ulpi_data_out;
    logic                 ulpi_data_oe;

    int fail_count;
    int tests_run;
    int tests_failed;
    int prop_fails;
    int fails_before;
    ulpi_pkg::ulpi_byte_t accepted[$]; // Bytes the PHY took with NXT high

    ulpi_link #(.NXT_TIMEOUT(NXT_TIMEOUT)) ulpi_link_i (
        .clk(clk), .rst(rst), .reg_wr(reg_wr), .reg_rd(reg_rd),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .reg_done(reg_done), .reg_err(reg_err), .busy(busy),
        .rx_cmd(rx_cmd), .rx_cmd_valid(rx_cmd_valid),
        .rx_data(rx_data), .rx_data_valid(rx_data_valid),
        .ulpi_dir(ulpi_dir), .ulpi_nxt(ulpi_nxt), .ulpi_stp(ulpi_stp),
        .ulpi_data_in(ulpi_data_in), .ulpi_data_out(ulpi_data_out),
        .ulpi_data_oe(ulpi_data_oe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 50 MHz stand-in for the 60 MHz PHY clock
    end

    task automatic check_value(string what, logic [7:0] expected, logic [7:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected %02h, actual %02h", what, expected, actual);
            fail_count++;
        end
    endtask

    task automatic check_bit(string what, logic expected, logic actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected %b, actual %b", what, expected, actual);
            fail_count++;
        end
    endtask

    task automatic check_in_time(logic ok, string what);
        assert (ok) else begin
            $display("%s", what);
            fail_count++;
        end
    endtask

    // PHY side of a register write, NXT after a random delay per byte
    task automatic serve_write(string name);
        int   cycles;
        int   delay;
        logic stp_seen;
        cycles   = 0;
        stp_seen = 1'b0;
        delay    = $urandom_range(3);
        accepted.delete();
        while (!stp_seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            ulpi_nxt = 1'b0;
            if (ulpi_stp) begin
                stp_seen = 1'b1;
                check_value({name, " stp data"}, 8'h00, ulpi_data_out);
                check_bit({name, " busy"}, 1'b1, busy); // Access still in flight
            end else if (ulpi_data_oe) begin
                if (delay == 0) begin
                    ulpi_nxt = 1'b1; // Taken at the next rising edge
                    accepted.push_back(ulpi_data_out);
                    delay = $urandom_range(3);
                end else begin
                    delay--;
                end
            end
        end
        check_in_time(stp_seen, {name, ": link never raised STP"});
    endtask

    task automatic check_write_bytes(string name);
        check_value({name, " accepted count"}, 8'd2, 8'(accepted.size()));
        if (accepted.size() >= 2) begin
            check_value({name, " tx cmd"}, {2'b10, reg_addr}, accepted[0]);
            check_value({name, " wdata"}, reg_wdata, accepted[1]);
        end
    endtask

    // PHY side of a register read, with both bus turnarounds
    task automatic serve_read(string name, output ulpi_pkg::ulpi_byte_t reg_byte);
        int cycles;
        int delay;
        int step;
        reg_byte = ulpi_pkg::ulpi_byte_t'($urandom);
        cycles   = 0;
        step     = 0;
        delay    = $urandom_range(3);
        accepted.delete();
        while (step < 4 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            check_bit({name, " rx_cmd_valid"}, 1'b0, rx_cmd_valid);   // Read bytes stay internal
            check_bit({name, " rx_data_valid"}, 1'b0, rx_data_valid);
            case (step)
                0: begin
                    ulpi_nxt = 1'b0;
                    if (ulpi_data_oe && delay == 0) begin
                        ulpi_nxt = 1'b1;
                        accepted.push_back(ulpi_data_out);
                        step = 1;
                    end else if (ulpi_data_oe) begin
                        delay--;
                    end
                end
                1: begin
                    ulpi_nxt     = 1'b0;
                    ulpi_dir     = 1'b1;
                    ulpi_data_in = ~reg_byte; // Turnaround, junk on the bus
                    step         = 2;
                end
                2: begin
                    ulpi_data_in = reg_byte;
                    step         = 3;
                end
                default: begin
                    ulpi_dir     = 1'b0; // PHY hands the bus back
                    ulpi_data_in = '0;
                    step         = 4;
                end
            endcase
        end
        ulpi_dir = 1'b0;
        ulpi_nxt = 1'b0;
        check_in_time(step == 4, {name, ": read sequence did not finish"});
    endtask

    // PHY takes the bus and sends RX CMD and packet bytes in random order
    task automatic drive_rx_burst(string name, int count);
        int                   prev_kind; // 0 none, 1 RX CMD, 2 packet byte
        ulpi_pkg::ulpi_byte_t prev_byte;
        ulpi_pkg::ulpi_byte_t b;
        logic                 is_data;
        prev_kind = 0;
        prev_byte = '0;
        for (int i = 0; i <= count + 2; i++) begin
            @(negedge clk);
            check_bit({name, " rx_cmd_valid"}, prev_kind == 1, rx_cmd_valid);
            check_bit({name, " rx_data_valid"}, prev_kind == 2, rx_data_valid);
            if (prev_kind == 1) check_value({name, " rx_cmd"}, prev_byte, rx_cmd);
            if (prev_kind == 2) check_value({name, " rx_data"}, prev_byte, rx_data);
            check_bit({name, " reg_done"}, 1'b0, reg_done);
            prev_kind = 0;
            if (i == 0) begin
                ulpi_dir     = 1'b1;
                ulpi_nxt     = 1'b0;
                ulpi_data_in = 8'hff; // Turnaround cycle
            end else if (i <= count) begin
                b            = ulpi_pkg::ulpi_byte_t'($urandom);
                is_data      = ($urandom_range(1) == 1);
                ulpi_nxt     = is_data;
                ulpi_data_in = b;
                prev_kind    = is_data ? 2 : 1;
                prev_byte    = b;
            end else if (i == count + 1) begin
                ulpi_dir     = 1'b0;
                ulpi_nxt     = 1'b0;
                ulpi_data_in = '0;
            end
        end
    endtask

    // Drops the request in the cycle reg_done is seen
    task automatic wait_reg_done(string name, int limit, output logic err,
                                 output ulpi_pkg::ulpi_byte_t rdata);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        err    = 1'bx;
        rdata  = 'x;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (reg_done) begin
                seen  = 1'b1;
                err   = reg_err;
                rdata = reg_rdata;
            end
        end
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        check_in_time(seen, {name, ": reg_done did not arrive in time"});
    endtask

    task automatic wait_idle(string name);
        int cycles;
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        check_in_time(!busy, {name, ": link stayed busy"});
    endtask

    task automatic run_write(string name);
        logic                 err;
        ulpi_pkg::ulpi_byte_t rdata;
        reg_addr  = ulpi_pkg::ulpi_addr_t'($urandom);
        reg_wdata = ulpi_pkg::ulpi_byte_t'($urandom);
        reg_wr    = 1'b1;
        serve_write(name);
        check_write_bytes(name);
        wait_reg_done(name, WAIT_LIMIT, err, rdata);
        check_bit({name, " reg_err"}, 1'b0, err);
        wait_idle(name);
    endtask

    task automatic run_read(string name);
        logic                 err;
        ulpi_pkg::ulpi_byte_t rdata;
        ulpi_pkg::ulpi_byte_t phy_byte;
        reg_addr = ulpi_pkg::ulpi_addr_t'($urandom);
        reg_rd   = 1'b1;
        serve_read(name, phy_byte);
        check_value({name, " accepted count"}, 8'd1, 8'(accepted.size()));
        if (accepted.size() >= 1) check_value({name, " tx cmd"}, {2'b11, reg_addr}, accepted[0]);
        wait_reg_done(name, WAIT_LIMIT, err, rdata);
        check_bit({name, " reg_err"}, 1'b0, err);
        check_value({name, " reg_rdata"}, phy_byte, rdata);
        wait_idle(name);
    endtask

    // DIR rises while the TX CMD waits for NXT, the write is issued again
    task automatic run_abort_retry(string name);
        int                   cycles;
        logic                 err;
        ulpi_pkg::ulpi_byte_t rdata;
        cycles    = 0;
        reg_addr  = ulpi_pkg::ulpi_addr_t'($urandom);
        reg_wdata = ulpi_pkg::ulpi_byte_t'($urandom);
        reg_wr    = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ulpi_data_oe && cycles < WAIT_LIMIT);
        check_in_time(ulpi_data_oe, {name, ": first TX CMD never driven"});
        check_value({name, " first tx cmd"}, {2'b10, reg_addr}, ulpi_data_out);
        drive_rx_burst(name, 3);
        serve_write(name);
        check_write_bytes(name);
        wait_reg_done(name, WAIT_LIMIT, err, rdata);
        check_bit({name, " reg_err"}, 1'b0, err);
        wait_idle(name);
    endtask

    task automatic run_timeout(string name);
        logic                 err;
        ulpi_pkg::ulpi_byte_t rdata;
        reg_addr  = ulpi_pkg::ulpi_addr_t'($urandom);
        reg_wdata = ulpi_pkg::ulpi_byte_t'($urandom);
        reg_wr    = 1'b1; // NXT stays low throughout
        wait_reg_done(name, NXT_TIMEOUT + 4, err, rdata);
        check_bit({name, " reg_err"}, 1'b1, err);
        wait_idle(name);
    endtask

    task automatic report_test(string name, int fails_at_start);
        tests_run++;
        if (fail_count == fails_at_start) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s %0d failed checks", name, fail_count - fails_at_start);
        end
    endtask

    initial begin
        void'($urandom(32'h6d3e9bc2));
        fail_count   = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        ulpi_dir     = 1'b0;
        ulpi_nxt     = 1'b0;
        ulpi_data_in = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        fails_before = fail_count;
        check_bit("reset ulpi_stp", 1'b0, ulpi_stp);
        check_bit("reset ulpi_data_oe", 1'b0, ulpi_data_oe);
        check_bit("reset reg_done", 1'b0, reg_done);
        check_bit("reset reg_err", 1'b0, reg_err);
        check_bit("reset busy", 1'b0, busy);
        check_bit("reset rx_cmd_valid", 1'b0, rx_cmd_valid);
        check_bit("reset rx_data_valid", 1'b0, rx_data_valid);
        rst = 1'b0;
        report_test("reset", fails_before);

        fails_before = fail_count;
        repeat (4) run_write("reg_write");
        report_test("reg_write", fails_before);

        fails_before = fail_count;
        repeat (4) run_read("reg_read");
        report_test("reg_read", fails_before);

        fails_before = fail_count;
        drive_rx_burst("receive", 4 + $urandom_range(4));
        wait_idle("receive");
        report_test("receive", fails_before);

        fails_before = fail_count;
        run_abort_retry("abort_retry");
        report_test("abort_retry", fails_before);

        fails_before = fail_count;
        run_timeout("timeout");
        report_test("timeout", fails_before);

        repeat (2) @(negedge clk);
        prop_fails = ulpi_link_i.ulpi_link_properties_i.fail_cnt;
        $display("tests %0d, failed tests %0d, failed checks %0d, assertion failures %0d",
                 tests_run, tests_failed, fail_count, prop_fails);
        if (fail_count == 0 && prop_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim/ulpi_link_properties.sv
// ULPI link protocol checks
// Bound to the link top level, watches bus ownership, STP length
// and the width of the completion pulse

`timescale 1ns/1ps

module ulpi_link_properties (
    input logic clk,
    input logic rst,
    input logic ulpi_dir,
    input logic ulpi_data_oe,
    input logic ulpi_stp,
    input logic reg_done
);

    int fail_cnt = 0; // Violations seen so far, read back by the testbench

    // Link must leave the bus to the PHY while DIR is high
    property no_drive_during_dir;
        @(posedge clk) disable iff (rst) ulpi_dir |-> !ulpi_data_oe;
    endproperty

    property stp_single_cycle;
        @(posedge clk) disable iff (rst) ulpi_stp |=> !ulpi_stp;
    endproperty

    property done_single_cycle;
        @(posedge clk) disable iff (rst) reg_done |=> !reg_done;
    endproperty

    assert property (no_drive_during_dir) else begin
        $error("link drives the ULPI bus while DIR is high");
        fail_cnt++;
    end

    assert property (stp_single_cycle) else begin
        $error("STP held high for more than one cycle");
        fail_cnt++;
    end

    assert property (done_single_cycle) else begin
        $error("reg_done longer than one cycle");
        fail_cnt++;
    end

endmodule

bind ulpi_link ulpi_link_properties ulpi_link_properties_i (
    .clk(clk), .rst(rst), .ulpi_dir(ulpi_dir), .ulpi_data_oe(ulpi_data_oe),
    .ulpi_stp(ulpi_stp), .reg_done(reg_done)
);
